/* trap_unit.f */
+incdir+design
design/trap_pkg.sv
design/trap_ctrl.sv
design/csr_file.sv
design/machine_timer.sv
design/trap_unit.sv
tb/trap_unit_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f trap_unit.f --top-module trap_unit_tb -Mdir obj_dir -o trap_unit_sim
	./obj_dir/trap_unit_sim

clean:
	rm -rf obj_dir

/* tb/trap_unit_tb.sv */
// trap unit testbench that plays the core and an apb master and checks trap timing and csr values
`include "trap_defs.svh"

module trap_unit_tb
    import trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CYCLE_LIMIT = 3000;
    localparam word_t NOP_WORD    = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t ECALL_WORD  = {`INST_ECALL, 13'd0, `OPCODE_SYSTEM};
    localparam word_t EBREAK_WORD = {`INST_EBREAK, 13'd0, `OPCODE_SYSTEM};
    localparam word_t MRET_WORD   = {`INST_MRET, 13'd0, `OPCODE_SYSTEM};

    logic      clk_i;
    logic      rst_i;
    word_t     inst_i;
    word_t     inst_addr_i;
    logic      jump_flag_i;
    word_t     jump_addr_i;
    logic      div_started_i;
    logic      irq_ext_i;
    logic      hold_flag_o;
    logic      int_assert_o;
    word_t     int_addr_o;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    csr_addr_t paddr_i;
    word_t     pwdata_i;
    word_t     prdata_o;
    logic      pready_o;
    logic      pslverr_o;

    integer seed = 32'hdd307fc4;
    int     cyc = 0;
    int     hold_from = 0;       // expected hold window in cycle numbers
    int     hold_to = 0;
    int     pulse_edge = -1;     // cycle in which int_assert_o is due
    word_t  pulse_addr = '0;
    logic   hold_due;
    logic   pulse_due;

    // expected csr contents
    word_t m_mstatus = '0;
    word_t m_mtvec = '0;
    word_t m_mepc = '0;
    word_t m_mcause = '0;

    trap_unit u_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .jump_flag_i   (jump_flag_i),
        .jump_addr_i   (jump_addr_i),
        .div_started_i (div_started_i),
        .irq_ext_i     (irq_ext_i),
        .hold_flag_o   (hold_flag_o),
        .int_assert_o  (int_assert_o),
        .int_addr_o    (int_addr_o),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        fail_run($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                           $time, name, exp_val, act_val));
    endtask

    // run limit
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            fail_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    assign hold_due  = (cyc >= hold_from) && (cyc < hold_to);
    assign pulse_due = (cyc == pulse_edge);

    assert property (@(posedge clk_i) disable iff (rst_i) hold_flag_o == hold_due)
        else report_mismatch("hold_flag_o", 32'($sampled(hold_due)), 32'($sampled(hold_flag_o)));
    assert property (@(posedge clk_i) disable iff (rst_i) int_assert_o == pulse_due)
        else report_mismatch("int_assert_o", 32'($sampled(pulse_due)),
                             32'($sampled(int_assert_o)));
    assert property (@(posedge clk_i) disable iff (rst_i) int_assert_o |-> int_addr_o == pulse_addr)
        else report_mismatch("int_addr_o", $sampled(pulse_addr), $sampled(int_addr_o));
    assert property (@(posedge clk_i) disable iff (rst_i) !penable_i |-> !pready_o)
        else fail_run("pready_o was high outside the APB access phase");

    // call right after the edge that puts the trigger on the inputs
    task automatic expect_trap(input int len, input word_t target);
        hold_from  = cyc + 1;  // cyc still shows the previous edge here
        hold_to    = cyc + 1 + len;
        pulse_edge = cyc + 1 + len;
        pulse_addr = target;
    endtask

    task automatic release_core();
        inst_i        <= NOP_WORD;
        jump_flag_i   <= 1'b0;
        div_started_i <= 1'b0;
        irq_ext_i     <= 1'b0;
    endtask

    // trigger stays on until the redirect edge where the core would flush it
    task automatic apply_trigger(input word_t inst, input word_t addr, input logic jump,
                                 input word_t jaddr, input logic ext, input int len,
                                 input word_t target);
        @(posedge clk_i);
        inst_i      <= inst;
        inst_addr_i <= addr;
        jump_flag_i <= jump;
        jump_addr_i <= jaddr;
        irq_ext_i   <= ext;
        expect_trap(len, target);
        repeat (len) @(posedge clk_i);
        release_core();
    endtask

    task automatic apb_xfer(input logic wr, input csr_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err, output int waits);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        waits = 0;
        @(negedge clk_i);
        while (!pready_o) begin
            waits++;
            if (waits > 16) begin
                fail_run("APB transfer never completed, pready_o stayed low");
            end
            @(negedge clk_i);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);  // completion edge
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic csr_write(input csr_addr_t addr, input word_t data);
        word_t rdata;
        logic  err;
        int    waits;
        apb_xfer(1'b1, addr, data, rdata, err, waits);
        assert (!err) else fail_run($sformatf("APB write to CSR %h returned pslverr_o", addr));
    endtask

    task automatic check_csr(input string name, input csr_addr_t addr, input word_t exp_val);
        word_t rdata;
        logic  err;
        int    waits;
        apb_xfer(1'b0, addr, '0, rdata, err, waits);
        assert (!err) else fail_run($sformatf("APB read of %s returned pslverr_o", name));
        assert (rdata == exp_val) else report_mismatch(name, exp_val, rdata);
    endtask

    // trap entry sets mepc and mcause and moves MIE into MPIE
    task automatic enter_model(input word_t cause, input word_t epc);
        m_mepc   = epc & ~word_t'(3);
        m_mcause = cause;
        m_mstatus[`MSTATUS_MPIE] = m_mstatus[`MSTATUS_MIE];
        m_mstatus[`MSTATUS_MIE]  = 1'b0;
    endtask

    task automatic check_trap_csrs();
        check_csr("mcause", `CSR_MCAUSE, m_mcause);
        check_csr("mepc", `CSR_MEPC, m_mepc);
        check_csr("mstatus", `CSR_MSTATUS, m_mstatus);
    endtask

    initial begin
        word_t val;
        word_t epc;
        word_t jaddr;
        word_t t0;
        word_t t1;
        logic  err;
        int    waits;
        rst_i         = 1'b1;
        inst_i        = NOP_WORD;
        inst_addr_i   = '0;
        jump_flag_i   = 1'b0;
        jump_addr_i   = '0;
        div_started_i = 1'b0;
        irq_ext_i     = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        // apb access and reset values
        check_csr("mstatus", `CSR_MSTATUS, '0);
        check_csr("mtimecmp", `CSR_MTIMECMP, '1);
        val = $random(seed);
        csr_write(`CSR_MTVEC, val);
        m_mtvec = val & ~word_t'(3);
        check_csr("mtvec", `CSR_MTVEC, m_mtvec);
        val = $random(seed);
        csr_write(`CSR_MEPC, val);
        check_csr("mepc", `CSR_MEPC, val & ~word_t'(3));
        apb_xfer(1'b0, 12'h123, '0, val, err, waits);
        assert (err) else fail_run("read of an unmapped address completed without pslverr_o");
        apb_xfer(1'b0, `CSR_MTIME, '0, t0, err, waits);
        csr_write(`CSR_MTIME, '0);  // dropped by the csr file
        apb_xfer(1'b0, `CSR_MTIME, '0, t1, err, waits);
        assert (t1 > t0) else fail_run("mtime stopped or was overwritten by an APB write");

        // ecall then ebreak under a taken jump
        csr_write(`CSR_MSTATUS, 32'h8);
        m_mstatus = 32'h8;
        epc = $random(seed) & ~32'h3;
        apply_trigger(ECALL_WORD, epc, 1'b0, '0, 1'b0, 4, m_mtvec);
        enter_model(`CAUSE_ECALL, epc);
        check_trap_csrs();
        jaddr = $random(seed) & ~32'h3;
        apply_trigger(EBREAK_WORD, epc + 32'h40, 1'b1, jaddr, 1'b0, 4, m_mtvec);
        enter_model(`CAUSE_EBREAK, jaddr - 32'd4);
        check_trap_csrs();

        // ecall held off by a divide in flight
        epc = $random(seed) & ~32'h3;
        @(posedge clk_i);
        inst_i        <= ECALL_WORD;
        inst_addr_i   <= epc;
        div_started_i <= 1'b1;
        repeat (6) @(posedge clk_i);
        div_started_i <= 1'b0;
        expect_trap(4, m_mtvec);
        repeat (4) @(posedge clk_i);
        release_core();
        enter_model(`CAUSE_ECALL, epc);
        check_trap_csrs();

        // timer and external irq pending before MIE is set, divide in flight, timer wins
        csr_write(`CSR_MTIMECMP, 32'h10);
        check_csr("mtimecmp", `CSR_MTIMECMP, 32'h10);
        epc = $random(seed) & ~32'h3;
        @(posedge clk_i);
        inst_addr_i   <= epc;
        div_started_i <= 1'b1;
        irq_ext_i     <= 1'b1;
        csr_write(`CSR_MSTATUS, 32'h8);
        expect_trap(4, m_mtvec);  // irq becomes pending at the write's completion edge
        repeat (4) @(posedge clk_i);
        release_core();
        m_mstatus = 32'h8;
        enter_model(`CAUSE_TIMER, epc - 32'd4);
        check_trap_csrs();
        csr_write(`CSR_MTIMECMP, '1);

        // external irq alone
        csr_write(`CSR_MSTATUS, 32'h8);
        m_mstatus = 32'h8;
        epc = $random(seed) & ~32'h3;
        apply_trigger(NOP_WORD, epc, 1'b0, '0, 1'b1, 4, m_mtvec);
        enter_model(`CAUSE_EXT, epc);
        check_trap_csrs();

        // external irq during a taken jump
        csr_write(`CSR_MSTATUS, 32'h8);
        m_mstatus = 32'h8;
        jaddr = $random(seed) & ~32'h3;
        apply_trigger(NOP_WORD, epc + 32'h40, 1'b1, jaddr, 1'b1, 4, m_mtvec);
        enter_model(`CAUSE_EXT, jaddr);
        check_trap_csrs();

        // both sources up with MIE clear and no trap expected
        csr_write(`CSR_MSTATUS, '0);
        m_mstatus = '0;
        csr_write(`CSR_MTIMECMP, 32'h10);
        @(posedge clk_i);
        irq_ext_i <= 1'b1;
        repeat (10) @(posedge clk_i);
        irq_ext_i <= 1'b0;
        csr_write(`CSR_MTIMECMP, '1);

        // mret restores MIE from MPIE
        csr_write(`CSR_MSTATUS, 32'h80);
        val = $random(seed);
        csr_write(`CSR_MEPC, val);
        m_mepc = val & ~word_t'(3);
        m_mstatus = 32'h88;
        apply_trigger(MRET_WORD, $random(seed) & ~32'h3, 1'b0, '0, 1'b0, 2, m_mepc);
        check_csr("mstatus", `CSR_MSTATUS, m_mstatus);

        // apb write lands in the middle of the trap writes
        epc = $random(seed) & ~32'h3;
        val = $random(seed);
        fork
            apply_trigger(ECALL_WORD, epc, 1'b0, '0, 1'b0, 4, m_mtvec);
            begin
                repeat (2) @(posedge clk_i);
                apb_xfer(1'b1, `CSR_MCAUSE, val, t0, err, waits);
            end
        join
        assert (waits > 0) else fail_run("APB write during a trap sequence got no wait state");
        assert (!err) else fail_run("APB write during a trap sequence returned pslverr_o");
        enter_model(`CAUSE_ECALL, epc);
        m_mcause = val;  // apb write completes after the trap's mcause write
        check_trap_csrs();

        repeat (4) @(posedge clk_i);
        $display("Test passed");
        $finish;
    end

endmodule

/* design/trap_unit.sv */
// trap unit top: trap controller, machine csr file and machine timer
module trap_unit
    import trap_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // core side
    input  word_t     inst_i,
    input  word_t     inst_addr_i,
    input  logic      jump_flag_i,
    input  word_t     jump_addr_i,
    input  logic      div_started_i,
    input  logic      irq_ext_i,
    output logic      hold_flag_o,
    output logic      int_assert_o,
    output word_t     int_addr_o,

    // apb slave
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  csr_addr_t paddr_i,
    input  word_t     pwdata_i,
    output word_t     prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    inst_u     inst_w;
    logic      csr_we;
    csr_addr_t csr_waddr;
    word_t     csr_wdata;
    word_t     mtvec;
    word_t     mepc;
    word_t     mstatus;
    word_t     mtimecmp;
    word_t     mtime;
    logic      timer_irq;

    assign inst_w.raw = inst_i;  // raw word in, field view used inside

    trap_ctrl u_trap_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .inst_i        (inst_w),
        .inst_addr_i   (inst_addr_i),
        .jump_flag_i   (jump_flag_i),
        .jump_addr_i   (jump_addr_i),
        .div_started_i (div_started_i),
        .timer_irq_i   (timer_irq),
        .irq_ext_i     (irq_ext_i),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .mstatus_i     (mstatus),
        .hold_flag_o   (hold_flag_o),
        .csr_we_o      (csr_we),
        .csr_waddr_o   (csr_waddr),
        .csr_wdata_o   (csr_wdata),
        .int_assert_o  (int_assert_o),
        .int_addr_o    (int_addr_o)
    );

    csr_file u_csr_file (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .trap_we_i    (csr_we),
        .trap_waddr_i (csr_waddr),
        .trap_wdata_i (csr_wdata),
        .mtime_i      (mtime),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .mstatus_o    (mstatus),
        .mtimecmp_o   (mtimecmp)
    );

    machine_timer u_machine_timer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mtimecmp_i  (mtimecmp),
        .mtime_o     (mtime),
        .timer_irq_o (timer_irq)
    );

endmodule

/* design/machine_timer.sv */
// machine timer: free-running mtime with a registered compare against mtimecmp
module machine_timer
    import trap_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  word_t mtimecmp_i,
    output word_t mtime_o,
    output logic  timer_irq_o  // level, held while mtime >= mtimecmp
);

    word_t mtime_q;

    // counts every cycle, wraps at the top
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + word_t'(1);
        end
    end

    // one cycle behind the compare
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime_q >= mtimecmp_i);
        end
    end

    assign mtime_o = mtime_q;

endmodule

/* design/csr_file.sv */
// machine csr file: trap write port plus apb slave access to the csrs
`include "trap_defs.svh"

module csr_file
    import trap_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // from trap_ctrl
    input  logic      trap_we_i,
    input  csr_addr_t trap_waddr_i,
    input  word_t     trap_wdata_i,

    input  word_t     mtime_i,  // from machine_timer

    // apb slave
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  csr_addr_t paddr_i,
    input  word_t     pwdata_i,
    output word_t     prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,

    // csr values
    output word_t     mtvec_o,
    output word_t     mepc_o,
    output word_t     mstatus_o,
    output word_t     mtimecmp_o
);

    word_t mstatus_q;
    word_t mtvec_q;
    word_t mepc_q;
    word_t mcause_q;
    word_t mtimecmp_q;

    logic      apb_access;
    logic      addr_hit;
    logic      apb_wr;
    logic      wr_en;
    csr_addr_t wr_addr;
    word_t     wr_data;

    assign apb_access = psel_i & penable_i;

    // wait state while the trap sequence writes
    assign pready_o = apb_access & ~trap_we_i;

    // address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `CSR_MSTATUS:  prdata_o = mstatus_q;
            `CSR_MTVEC:    prdata_o = mtvec_q;
            `CSR_MEPC:     prdata_o = mepc_q;
            `CSR_MCAUSE:   prdata_o = mcause_q;
            `CSR_MTIME:    prdata_o = mtime_i;
            `CSR_MTIMECMP: prdata_o = mtimecmp_q;
            default:       addr_hit = 1'b0;
        endcase
    end

    assign pslverr_o = pready_o & ~addr_hit;
    assign apb_wr    = pready_o & pwrite_i & addr_hit;

    // shared write port, the two sides never overlap
    assign wr_en   = trap_we_i | apb_wr;
    assign wr_addr = trap_we_i ? trap_waddr_i : paddr_i;
    assign wr_data = trap_we_i ? trap_wdata_i : pwdata_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtimecmp_q <= '1;  // no timer irq until software sets it
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_MSTATUS:  mstatus_q  <= wr_data;
                `CSR_MTVEC:    mtvec_q    <= {wr_data[`XLEN-1:2], 2'b00};  // word aligned
                `CSR_MEPC:     mepc_q     <= {wr_data[`XLEN-1:2], 2'b00};
                `CSR_MCAUSE:   mcause_q   <= wr_data;
                `CSR_MTIMECMP: mtimecmp_q <= wr_data;
                default: ;  // mtime writes dropped
            endcase
        end
    end

    assign mtvec_o    = mtvec_q;
    assign mepc_o     = mepc_q;
    assign mstatus_o  = mstatus_q;
    assign mtimecmp_o = mtimecmp_q;

endmodule

/* design/trap_ctrl.sv */
// trap controller: arbitrates ecall, ebreak, interrupts and mret, writes csrs, redirects
`include "trap_defs.svh"

module trap_ctrl
    import trap_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // decode stage
    input  inst_u     inst_i,
    input  word_t     inst_addr_i,

    // execute stage
    input  logic      jump_flag_i,
    input  word_t     jump_addr_i,
    input  logic      div_started_i,

    // interrupt sources
    input  logic      timer_irq_i,
    input  logic      irq_ext_i,

    // current csr values
    input  word_t     mtvec_i,
    input  word_t     mepc_i,
    input  word_t     mstatus_i,

    output logic      hold_flag_o,  // stall the pipeline

    // csr write port
    output logic      csr_we_o,
    output csr_addr_t csr_waddr_o,
    output word_t     csr_wdata_o,

    // redirect to the core
    output logic      int_assert_o,
    output word_t     int_addr_o
);

    // one-hot sequencer states
    localparam logic [4:0] SEQ_IDLE    = 5'b00001;
    localparam logic [4:0] SEQ_MEPC    = 5'b00010;
    localparam logic [4:0] SEQ_MSTATUS = 5'b00100;
    localparam logic [4:0] SEQ_MCAUSE  = 5'b01000;
    localparam logic [4:0] SEQ_MRET    = 5'b10000;

    logic [4:0] seq_q;

    logic  is_system;
    logic  is_ecall;
    logic  is_ebreak;
    logic  is_mret;
    logic  irq_pending;
    logic  take_sync;
    logic  take_irq;
    logic  take_mret;
    word_t ret_addr_q;   // value for mepc
    word_t cause_q;      // value for mcause
    word_t mstatus_entry;
    word_t mstatus_exit;

    // system op with rs1, rd and funct3 all zero
    assign is_system = (inst_i.sys.opcode == `OPCODE_SYSTEM) && (inst_i.sys.rs1 == 5'd0)
                    && (inst_i.sys.rd == 5'd0) && (inst_i.sys.funct3 == 3'd0);
    assign is_ecall  = is_system && (inst_i.sys.funct12 == `INST_ECALL);
    assign is_ebreak = is_system && (inst_i.sys.funct12 == `INST_EBREAK);
    assign is_mret   = is_system && (inst_i.sys.funct12 == `INST_MRET);

    assign irq_pending = mstatus_i[`MSTATUS_MIE] & (timer_irq_i | irq_ext_i);

    // priority: sync trap, then interrupt, then mret
    always_comb begin
        take_sync = 1'b0;
        take_irq  = 1'b0;
        take_mret = 1'b0;
        if (is_ecall || is_ebreak) begin
            take_sync = ~div_started_i;  // wait for the divide to finish
        end else if (irq_pending) begin
            take_irq = 1'b1;
        end else if (is_mret) begin
            take_mret = 1'b1;
        end
    end

    assign hold_flag_o = (seq_q != SEQ_IDLE) | take_sync | take_irq | take_mret;

    // mstatus images for entry and return
    always_comb begin
        mstatus_entry = mstatus_i;
        mstatus_entry[`MSTATUS_MPIE] = mstatus_i[`MSTATUS_MIE];
        mstatus_entry[`MSTATUS_MIE]  = 1'b0;
        mstatus_exit = mstatus_i;
        mstatus_exit[`MSTATUS_MIE] = mstatus_i[`MSTATUS_MPIE];
    end

    // sequencer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            seq_q <= SEQ_IDLE;
        end else begin
            case (seq_q)
                SEQ_IDLE: begin
                    if (take_sync || take_irq) begin
                        seq_q <= SEQ_MEPC;
                    end else if (take_mret) begin
                        seq_q <= SEQ_MRET;
                    end
                end
                SEQ_MEPC:    seq_q <= SEQ_MSTATUS;
                SEQ_MSTATUS: seq_q <= SEQ_MCAUSE;
                default:     seq_q <= SEQ_IDLE;  // mcause and mret end here
            endcase
        end
    end

    // latch return address and cause when a trap is accepted
    always_ff @(posedge clk_i) begin
        if (seq_q == SEQ_IDLE) begin
            if (take_sync) begin
                // handler adds 4 back to mepc
                ret_addr_q <= jump_flag_i ? jump_addr_i - word_t'(4) : inst_addr_i;
                cause_q    <= is_ecall ? `CAUSE_ECALL : `CAUSE_EBREAK;
            end else if (take_irq) begin
                if (jump_flag_i) begin
                    ret_addr_q <= jump_addr_i;
                end else if (div_started_i) begin
                    ret_addr_q <= inst_addr_i - word_t'(4);  // re-run the divide
                end else begin
                    ret_addr_q <= inst_addr_i;
                end
                cause_q <= timer_irq_i ? `CAUSE_TIMER : `CAUSE_EXT;  // timer first
            end
        end
    end

    // strobes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            csr_we_o     <= 1'b0;
            int_assert_o <= 1'b0;
        end else begin
            csr_we_o     <= (seq_q != SEQ_IDLE);
            int_assert_o <= (seq_q == SEQ_MCAUSE) || (seq_q == SEQ_MRET);
        end
    end

    // write data and redirect target
    always_ff @(posedge clk_i) begin
        case (seq_q)
            SEQ_MEPC: begin
                csr_waddr_o <= `CSR_MEPC;
                csr_wdata_o <= ret_addr_q;
            end
            SEQ_MSTATUS: begin
                csr_waddr_o <= `CSR_MSTATUS;
                csr_wdata_o <= mstatus_entry;
            end
            SEQ_MCAUSE: begin
                csr_waddr_o <= `CSR_MCAUSE;
                csr_wdata_o <= cause_q;
            end
            default: begin
                csr_waddr_o <= `CSR_MSTATUS;  // mret, or don't care when idle
                csr_wdata_o <= mstatus_exit;
            end
        endcase
        int_addr_o <= (seq_q == SEQ_MRET) ? mepc_i : mtvec_i;
    end

endmodule

/* design/trap_pkg.sv */
// trap package: data word, csr number and instruction word types
`include "trap_defs.svh"

package trap_pkg;

    // data or address word
    typedef logic [`XLEN-1:0] word_t;

    // csr number, also the apb address
    typedef logic [11:0] csr_addr_t;

    // i-type layout as used by ecall, ebreak and mret
    typedef struct packed {
        logic [11:0] funct12;  // selects the system op
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } sys_inst_t;

    // instruction word seen raw or as system fields
    typedef union packed {
        word_t     raw;
        sys_inst_t sys;
    } inst_u;

endpackage

/* design/trap_defs.svh */
// trap unit constants: word width, csr numbers, trap causes and system encodings
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// data path
`define XLEN 32

// machine csr numbers, doubling as apb addresses
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTIME    12'h7c0  // custom, read only from apb
`define CSR_MTIMECMP 12'h7c1  // custom

// mstatus bit positions
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7

// mcause values
`define CAUSE_EBREAK 32'h0000_0003
`define CAUSE_ECALL  32'h0000_000b
`define CAUSE_TIMER  32'h8000_0007  // top bit marks an interrupt
`define CAUSE_EXT    32'h8000_000b

// SYSTEM opcode and its funct12 values
`define OPCODE_SYSTEM 7'b111_0011
`define INST_ECALL    12'h000
`define INST_EBREAK   12'h001
`define INST_MRET     12'h302

`endif
